/* acq_pkg.sv */
package acq_pkg;

    //////////////////////////////////////////////////////////////////////
    // Channel and frame geometry
    //////////////////////////////////////////////////////////////////////

    localparam int NUM_CH          = 4;
    localparam int SCANS_PER_FRAME = 4;
    // One byte per sample, so a frame is NUM_CH x SCANS_PER_FRAME bytes.
    localparam int FRAME_BYTES     = 16;

    localparam int CH_W   = $clog2(NUM_CH);
    localparam int SCAN_W = $clog2(SCANS_PER_FRAME);
    localparam int FIDX_W = $clog2(FRAME_BYTES);

    //////////////////////////////////////////////////////////////////////
    // SPI timing and command set
    //////////////////////////////////////////////////////////////////////

    // sys_clk cycles per SPI clock half period.
    localparam int SCLK_DIV = 2;
    localparam int DIV_W    = $clog2(SCLK_DIV);

    localparam logic [7:0] DEV_ID    = 8'hA5;
    localparam logic [7:0] CMD_ID    = 8'h80;
    localparam logic [7:0] CMD_CONF  = 8'h40;
    // Channel number goes in the low bits.
    localparam logic [7:0] CMD_READ  = 8'h00;
    // All four channels enabled.
    localparam logic [7:0] CONF_WORD = 8'h0F;

    typedef enum logic [7:0] {
        IDLE  = 8'h00,
        CHECK = 8'h01,
        CONF  = 8'h02,
        PREP  = 8'h03,
        SCAN  = 8'h04,
        COUNT = 8'h05,
        SEND  = 8'h06,
        LAST  = 8'h07
    } acq_state_t;

endpackage

/* acq_sequencer.sv */
`timescale 1ns/1ps

module acq_sequencer (
    input  logic                sys_clk,
    input  logic                rst,
    input  logic                run,
    output logic                fs_check,
    output logic                fs_conf,
    output logic                fs_scan,
    output logic                fs_send,
    input  logic                fd_check,
    input  logic                id_ok,
    input  logic                fd_conf,
    input  logic                fd_scan,
    input  logic                fd_send,
    output logic [1:0]          scan_idx,
    output logic                bank,
    output acq_pkg::acq_state_t state
);
    import acq_pkg::*;

    acq_state_t        next_state;
    logic [SCAN_W-1:0] scan_cnt;
    logic              retry;

    // A wrong ID keeps the machine in CHECK and starts another read.
    assign retry    = fd_check && !id_ok;
    assign scan_idx = scan_cnt;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            IDLE:  next_state = CHECK;
            CHECK: if (fd_check && id_ok) next_state = CONF;
            CONF:  if (fd_conf) next_state = PREP;
            PREP:  if (run) next_state = SCAN;
            SCAN:  if (fd_scan) next_state = COUNT;
            COUNT: begin
                if (scan_cnt == SCAN_W'(SCANS_PER_FRAME - 1)) begin
                    next_state = SEND;
                end else begin
                    next_state = LAST;
                end
            end
            SEND:  if (fd_send) next_state = LAST;
            LAST:  next_state = PREP;
            default: next_state = IDLE;
        endcase
    end

    // Start pulses land on the first cycle of their state.
    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            fs_check <= 1'b0;
            fs_conf  <= 1'b0;
            fs_scan  <= 1'b0;
            fs_send  <= 1'b0;
        end else begin
            fs_check <= (next_state == CHECK) && ((state != CHECK) || retry);
            fs_conf  <= (next_state == CONF) && (state != CONF);
            fs_scan  <= (next_state == SCAN) && (state != SCAN);
            fs_send  <= (next_state == SEND) && (state != SEND);
        end
    end

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            scan_cnt <= '0;
            bank     <= 1'b0;
        end else if (state == COUNT) begin
            scan_cnt <= scan_cnt + 1'b1;
        end else if ((state == SEND) && fd_send) begin
            // Streamer has the full bank, capture moves to the other one.
            scan_cnt <= '0;
            bank     <= ~bank;
        end
    end

    a_one_start: assert property (@(posedge sys_clk) disable iff (rst)
        $onehot0({fs_check, fs_conf, fs_scan, fs_send}));

endmodule

/* acq_top.sv */
`timescale 1ns/1ps

module acq_top (
    input  logic                sys_clk,
    input  logic                rst,
    input  logic                run,
    output logic                spi_cs_n,
    output logic                spi_sclk,
    output logic                spi_mosi,
    input  logic                spi_miso,
    output logic [7:0]          out_data,
    output logic                out_valid,
    output logic                out_last,
    input  logic                out_ready,
    output acq_pkg::acq_state_t state
);
    import bus_pkg::*;

    logic       fs_check, fd_check, id_ok;
    logic       fs_conf, fd_conf;
    logic       fs_scan, fd_scan;
    logic       fs_send, fd_send;
    logic [1:0] scan_idx;
    logic       bank;

    wb_req_t m0_req, m1_req, s_req;
    wb_rsp_t m0_rsp, m1_rsp, s_rsp;

    acq_sequencer seq_i (
        .sys_clk(sys_clk), .rst(rst), .run(run),
        .fs_check(fs_check), .fs_conf(fs_conf), .fs_scan(fs_scan), .fs_send(fs_send),
        .fd_check(fd_check), .id_ok(id_ok), .fd_conf(fd_conf),
        .fd_scan(fd_scan), .fd_send(fd_send),
        .scan_idx(scan_idx), .bank(bank), .state(state)
    );

    // Capture is bus master 0.
    adc_capture cap_i (
        .sys_clk(sys_clk), .rst(rst),
        .fs_check(fs_check), .fs_conf(fs_conf), .fs_scan(fs_scan),
        .scan_idx(scan_idx), .bank(bank),
        .fd_check(fd_check), .id_ok(id_ok), .fd_conf(fd_conf), .fd_scan(fd_scan),
        .spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .wb_req(m0_req), .wb_rsp(m0_rsp)
    );

    frame_streamer str_i (
        .sys_clk(sys_clk), .rst(rst), .fs_send(fs_send), .bank(bank), .fd_send(fd_send),
        .wb_req(m1_req), .wb_rsp(m1_rsp),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_ready(out_ready)
    );

    wb_arbiter arb_i (
        .sys_clk(sys_clk), .rst(rst),
        .m0_req(m0_req), .m1_req(m1_req), .m0_rsp(m0_rsp), .m1_rsp(m1_rsp),
        .s_req(s_req), .s_rsp(s_rsp)
    );

    sample_ram ram_i (
        .sys_clk(sys_clk), .rst(rst), .wb_req(s_req), .wb_rsp(s_rsp)
    );

endmodule

/* adc_capture.sv */
`timescale 1ns/1ps

module adc_capture (
    input  logic             sys_clk,
    input  logic             rst,
    input  logic             fs_check,
    input  logic             fs_conf,
    input  logic             fs_scan,
    input  logic [1:0]       scan_idx,
    input  logic             bank,
    output logic             fd_check,
    output logic             id_ok,
    output logic             fd_conf,
    output logic             fd_scan,
    output logic             spi_cs_n,
    output logic             spi_sclk,
    output logic             spi_mosi,
    input  logic             spi_miso,
    output bus_pkg::wb_req_t wb_req,
    input  bus_pkg::wb_rsp_t wb_rsp
);
    import acq_pkg::*;

    typedef enum logic [2:0] {ST_IDLE, ST_SETUP, ST_SHIFT, ST_HOLD, ST_WRITE} cap_state_t;
    typedef enum logic [1:0] {OP_CHECK, OP_CONF, OP_SCAN} cap_op_t;

    cap_state_t       st;
    cap_op_t          op;
    logic [DIV_W-1:0] div_cnt;
    logic [3:0]       bit_cnt;
    logic [CH_W-1:0]  ch;
    logic [15:0]      tx_sr;
    logic [7:0]       rx_sr;

    // Mode 0, MSB first.
    assign spi_mosi = tx_sr[15];

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            st       <= ST_IDLE;
            op       <= OP_CHECK;
            div_cnt  <= '0;
            bit_cnt  <= '0;
            ch       <= '0;
            tx_sr    <= '0;
            rx_sr    <= '0;
            spi_cs_n <= 1'b1;
            spi_sclk <= 1'b0;
            fd_check <= 1'b0;
            id_ok    <= 1'b0;
            fd_conf  <= 1'b0;
            fd_scan  <= 1'b0;
            wb_req   <= '0;
        end else begin
            fd_check <= 1'b0;
            fd_conf  <= 1'b0;
            fd_scan  <= 1'b0;
            case (st)
                ST_IDLE: begin
                    if (fs_check || fs_conf || fs_scan) begin
                        spi_cs_n <= 1'b0;
                        st       <= ST_SETUP;
                    end
                    if (fs_check) begin
                        op    <= OP_CHECK;
                        tx_sr <= {CMD_ID, 8'h00};
                    end else if (fs_conf) begin
                        op    <= OP_CONF;
                        tx_sr <= {CMD_CONF, CONF_WORD};
                    end else if (fs_scan) begin
                        op    <= OP_SCAN;
                        ch    <= '0;
                        tx_sr <= {CMD_READ, 8'h00};
                    end
                end
                // One cycle of chip-select setup before the first edge.
                ST_SETUP: begin
                    div_cnt <= '0;
                    bit_cnt <= '0;
                    st      <= ST_SHIFT;
                end
                ST_SHIFT: begin
                    if (div_cnt == DIV_W'(SCLK_DIV - 1)) begin
                        div_cnt  <= '0;
                        spi_sclk <= ~spi_sclk;
                        if (!spi_sclk) begin
                            // Reply byte is sampled on rising edges of bits 8 to 15.
                            if (bit_cnt[3]) rx_sr <= {rx_sr[6:0], spi_miso};
                        end else begin
                            tx_sr   <= {tx_sr[14:0], 1'b0};
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == 4'd15) st <= ST_HOLD;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                ST_HOLD: begin
                    spi_cs_n <= 1'b1;
                    case (op)
                        OP_CHECK: begin
                            fd_check <= 1'b1;
                            id_ok    <= (rx_sr == DEV_ID);
                            st       <= ST_IDLE;
                        end
                        OP_CONF: begin
                            fd_conf <= 1'b1;
                            st      <= ST_IDLE;
                        end
                        default: begin
                            wb_req.cyc <= 1'b1;
                            wb_req.stb <= 1'b1;
                            wb_req.we  <= 1'b1;
                            wb_req.adr <= {bank, scan_idx, ch};
                            wb_req.dat <= rx_sr;
                            st         <= ST_WRITE;
                        end
                    endcase
                end
                ST_WRITE: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        if (ch == CH_W'(NUM_CH - 1)) begin
                            fd_scan <= 1'b1;
                            st      <= ST_IDLE;
                        end else begin
                            ch       <= ch + 1'b1;
                            tx_sr    <= {CMD_READ | 8'(ch + 1'b1), 8'h00};
                            spi_cs_n <= 1'b0;
                            st       <= ST_SETUP;
                        end
                    end
                end
                default: st <= ST_IDLE;
            endcase
        end
    end

    a_req_hold: assert property (@(posedge sys_clk) disable iff (rst)
        wb_req.cyc && !wb_rsp.ack |=> $stable(wb_req));

endmodule

/* bus_pkg.sv */
package bus_pkg;

    //////////////////////////////////////////////////////////////////////
    // Wishbone classic bus to the sample memory
    //////////////////////////////////////////////////////////////////////

    // Five address bits cover two 16-byte frame banks.
    localparam int WB_AW = 5;
    localparam int WB_DW = 8;

    // Master to slave.
    typedef struct packed {
        logic             cyc;
        logic             stb;
        logic             we;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    // Slave to master. Read data is valid with ack.
    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;
    } wb_rsp_t;

endpackage

/* frame_streamer.sv */
`timescale 1ns/1ps

module frame_streamer (
    input  logic             sys_clk,
    input  logic             rst,
    input  logic             fs_send,
    input  logic             bank,
    output logic             fd_send,
    output bus_pkg::wb_req_t wb_req,
    input  bus_pkg::wb_rsp_t wb_rsp,
    output logic [7:0]       out_data,
    output logic             out_valid,
    output logic             out_last,
    input  logic             out_ready
);
    import acq_pkg::*;

    typedef enum logic [1:0] {F_IDLE, F_READ, F_OUT} str_state_t;

    str_state_t        st;
    logic              bank_q;
    logic [FIDX_W-1:0] idx;
    logic              pend;

    // A send request that arrives mid-frame is served once the frame ends.
    assign fd_send = (st == F_IDLE) && (fs_send || pend);

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            st        <= F_IDLE;
            bank_q    <= 1'b0;
            idx       <= '0;
            pend      <= 1'b0;
            wb_req    <= '0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else begin
            if (fs_send && (st != F_IDLE)) pend <= 1'b1;
            case (st)
                F_IDLE: begin
                    if (fd_send) begin
                        bank_q     <= bank;
                        idx        <= '0;
                        pend       <= 1'b0;
                        wb_req.cyc <= 1'b1;
                        wb_req.stb <= 1'b1;
                        wb_req.we  <= 1'b0;
                        wb_req.adr <= {bank, {FIDX_W{1'b0}}};
                        wb_req.dat <= '0;
                        st         <= F_READ;
                    end
                end
                F_READ: begin
                    if (wb_rsp.ack) begin
                        wb_req.cyc <= 1'b0;
                        wb_req.stb <= 1'b0;
                        out_valid  <= 1'b1;
                        out_last   <= (idx == FIDX_W'(FRAME_BYTES - 1));
                        st         <= F_OUT;
                    end
                end
                F_OUT: begin
                    if (out_ready) begin
                        out_valid <= 1'b0;
                        out_last  <= 1'b0;
                        if (out_last) begin
                            st <= F_IDLE;
                        end else begin
                            idx        <= idx + 1'b1;
                            wb_req.cyc <= 1'b1;
                            wb_req.stb <= 1'b1;
                            wb_req.adr <= {bank_q, idx + 1'b1};
                            st         <= F_READ;
                        end
                    end
                end
                default: st <= F_IDLE;
            endcase
        end
    end

    always_ff @(posedge sys_clk) begin
        if ((st == F_READ) && wb_rsp.ack) out_data <= wb_rsp.dat;
    end

    a_out_hold: assert property (@(posedge sys_clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last));

endmodule

/* project.f */
acq_pkg.sv
bus_pkg.sv
acq_sequencer.sv
adc_capture.sv
frame_streamer.sv
wb_arbiter.sv
sample_ram.sv
acq_top.sv
tb_adc_model.sv
tb_acq.sv

/* sample_ram.sv */
`timescale 1ns/1ps

module sample_ram (
    input  logic             sys_clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t wb_req,
    output bus_pkg::wb_rsp_t wb_rsp
);
    import bus_pkg::*;

    logic [WB_DW-1:0] mem [2**WB_AW];
    logic             ack_q;
    logic [WB_DW-1:0] rd_q;
    logic             hit;

    // A new access only starts once the previous ack has gone.
    assign hit = wb_req.cyc && wb_req.stb && !ack_q;

    assign wb_rsp.ack = ack_q;
    assign wb_rsp.dat = rd_q;

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= hit;
        end
    end

    always_ff @(posedge sys_clk) begin
        if (hit) begin
            if (wb_req.we) mem[wb_req.adr] <= wb_req.dat;
            rd_q <= mem[wb_req.adr];
        end
    end

endmodule

/* tb_acq.sv */
`timescale 1ns/1ps

module tb_acq;
    import acq_pkg::*;

    localparam int         timeout_cycles = 40000;
    localparam logic [7:0] good_id        = 8'hA5;
    localparam logic [7:0] bad_id         = 8'h3C;
    localparam logic [7:0] exp_conf       = 8'h0F;

    logic        sys_clk;
    logic        rst;
    logic        run;
    logic        spi_cs_n;
    logic        spi_sclk;
    logic        spi_mosi;
    logic        spi_miso;
    logic [7:0]  out_data;
    logic        out_valid;
    logic        out_last;
    logic        out_ready;
    acq_state_t  state;
    logic [7:0]  model_id;
    logic [7:0]  conf_byte;
    logic [15:0] sample_cnt;
    logic [15:0] id_reads;

    int          seed;
    int          errors;
    int          checks;
    int          byte_idx;
    int          cycle_cnt;
    logic [1:0]  ready_mode;
    logic [7:0]  rx_data_q[$];
    logic        rx_last_q[$];
    logic        prev_hold;
    logic [7:0]  prev_data;
    logic        prev_last;
    logic        last_seen;

    acq_top dut_i (
        .sys_clk(sys_clk), .rst(rst), .run(run),
        .spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .out_data(out_data), .out_valid(out_valid), .out_last(out_last),
        .out_ready(out_ready), .state(state)
    );

    tb_adc_model adc_i (
        .spi_cs_n(spi_cs_n), .spi_sclk(spi_sclk), .spi_mosi(spi_mosi), .spi_miso(spi_miso),
        .dev_id(model_id), .conf_byte(conf_byte), .sample_cnt(sample_cnt),
        .id_reads(id_reads)
    );

    initial begin
        sys_clk = 1'b0;
        forever #20 sys_clk = ~sys_clk;
    end

    // Ready mode 0 holds out_ready low, 1 holds it high and 2 draws it at random.
    always @(posedge sys_clk) begin
        #2;
        case (ready_mode)
            2'd1:    out_ready = 1'b1;
            2'd2:    out_ready = (($random(seed) % 2) != 0);
            default: out_ready = 1'b0;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Stream monitor sampled mid-cycle
    //////////////////////////////////////////////////////////////////////

    always @(negedge sys_clk) begin
        if (!rst) begin
            if (prev_hold) begin
                compare_value("out_valid held", out_valid, 1'b1);
                compare_value("out_data held", out_data, prev_data);
                compare_value("out_last held", out_last, prev_last);
            end
            if (out_valid && out_ready) begin
                rx_data_q.push_back(out_data);
                rx_last_q.push_back(out_last);
            end
            prev_hold = out_valid && !out_ready;
            prev_data = out_data;
            prev_last = out_last;
        end
    end

    initial begin
        cycle_cnt = 0;
        while (cycle_cnt < timeout_cycles) begin
            @(posedge sys_clk);
            cycle_cnt++;
        end
        $display("Timeout: tests still running after %0d cycles", timeout_cycles);
        $display("CHECKS FAILED");
        $finish;
    end

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic report_problem(input string what);
        errors++;
        $display("ERROR: %s", what);
    endtask

    task automatic end_test(input int num, input string title, input int errs_before);
        if (errors == errs_before) begin
            $display("test %0d %s: ok", num, title);
        end else begin
            $display("test %0d %s: %0d errors", num, title, errors - errs_before);
        end
    endtask

    task automatic wait_state(input acq_state_t target, input int limit);
        int waited;
        waited = 0;
        while ((state != target) && (waited < limit)) begin
            @(negedge sys_clk);
            waited++;
        end
        if (state != target) begin
            report_problem($sformatf("state did not reach %s in %0d cycles",
                target.name(), limit));
        end
    endtask

    // Bytes must count up from zero, with out_last on every 16th.
    task automatic take_bytes(input int n, input int limit);
        int         waited;
        logic [7:0] data;
        logic       last;
        waited = 0;
        while ((rx_data_q.size() < n) && (waited < limit)) begin
            @(negedge sys_clk);
            waited++;
        end
        if (rx_data_q.size() < n) begin
            report_problem($sformatf("only %0d of %0d stream bytes arrived in %0d cycles",
                rx_data_q.size(), n, limit));
        end
        while ((n > 0) && (rx_data_q.size() > 0)) begin
            data = rx_data_q.pop_front();
            last = rx_last_q.pop_front();
            compare_value($sformatf("out_data[%0d]", byte_idx), data, byte_idx[7:0]);
            compare_value($sformatf("out_last[%0d]", byte_idx), last, (byte_idx % 16) == 15);
            last_seen = last;
            byte_idx++;
            n--;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Directed tests
    //////////////////////////////////////////////////////////////////////

    task automatic reset_values();
        int e0;
        e0 = errors;
        @(negedge sys_clk);
        compare_value("spi_cs_n", spi_cs_n, 1'b1);
        compare_value("spi_sclk", spi_sclk, 1'b0);
        compare_value("out_valid", out_valid, 1'b0);
        compare_value("state", state, IDLE);
        @(posedge sys_clk);
        #2 rst = 1'b0;
        repeat (2) begin
            @(negedge sys_clk);
            compare_value("spi_cs_n", spi_cs_n, 1'b1);
            compare_value("spi_sclk", spi_sclk, 1'b0);
            compare_value("out_valid", out_valid, 1'b0);
            compare_value("state is IDLE or CHECK", (state == IDLE) || (state == CHECK), 1'b1);
        end
        end_test(1, "reset", e0);
    endtask

    task automatic bad_id_retry();
        int e0;
        int waited;
        e0 = errors;
        waited = 0;
        while ((id_reads < 16'd3) && (waited < 1000)) begin
            @(negedge sys_clk);
            waited++;
            compare_value("state", state, CHECK);
            compare_value("out_valid", out_valid, 1'b0);
        end
        if (id_reads < 16'd3) report_problem("fewer than three ID reads with a wrong ID");
        @(posedge sys_clk);
        #2 model_id = good_id;
        wait_state(PREP, 1000);
        end_test(2, "device ID retry", e0);
    endtask

    task automatic conf_readback();
        int e0;
        e0 = errors;
        compare_value("conf_byte", conf_byte, exp_conf);
        end_test(3, "configuration write", e0);
    endtask

    task automatic first_frame();
        int e0;
        e0 = errors;
        compare_value("out_valid before run", out_valid, 1'b0);
        ready_mode = 2'd1;
        @(posedge sys_clk);
        #2 run = 1'b1;
        take_bytes(16, 4000);
        end_test(4, "first frame, ready high", e0);
    endtask

    task automatic random_ready_frames();
        int e0;
        e0 = errors;
        ready_mode = 2'd2;
        take_bytes(48, 8000);
        end_test(5, "three frames, random ready", e0);
    endtask

    task automatic stop_after_frame();
        int          e0;
        int          waited;
        logic [15:0] cnt0;
        e0 = errors;
        ready_mode = 2'd1;
        waited = 0;
        // Drop run during the last scan of a frame.
        while ((sample_cnt[3:0] != 4'd13) && (waited < 2000)) begin
            @(negedge sys_clk);
            waited++;
        end
        if (sample_cnt[3:0] != 4'd13) report_problem("last scan of a frame never started");
        @(posedge sys_clk);
        #2 run = 1'b0;
        wait_state(PREP, 2000);
        take_bytes(int'(sample_cnt) - byte_idx, 3000);
        cnt0 = sample_cnt;
        repeat (400) @(negedge sys_clk);
        compare_value("bytes after stop", rx_data_q.size(), 0);
        compare_value("sample_cnt after stop", sample_cnt, cnt0);
        compare_value("sample_cnt mod 16", sample_cnt % 16, 0);
        compare_value("out_last on final byte", last_seen, 1'b1);
        compare_value("bytes streamed", byte_idx, sample_cnt);
        end_test(6, "stop after frame", e0);
    endtask

    initial begin
        rst        = 1'b1;
        run        = 1'b0;
        out_ready  = 1'b0;
        model_id   = bad_id;
        ready_mode = 2'd0;
        seed       = 96197;
        errors     = 0;
        checks     = 0;
        byte_idx   = 0;
        prev_hold  = 1'b0;
        prev_data  = 8'h00;
        prev_last  = 1'b0;
        last_seen  = 1'b0;

        reset_values();
        bad_id_retry();
        conf_readback();
        first_frame();
        random_ready_frames();
        stop_after_frame();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

/* tb_adc_model.sv */
`timescale 1ns/1ps

module tb_adc_model (
    input  logic        spi_cs_n,
    input  logic        spi_sclk,
    input  logic        spi_mosi,
    output logic        spi_miso,
    input  logic [7:0]  dev_id,
    output logic [7:0]  conf_byte,
    output logic [15:0] sample_cnt,
    output logic [15:0] id_reads
);

    logic [15:0] shift_in;
    logic [7:0]  reply;
    int          bit_n;

    initial begin
        spi_miso   = 1'b0;
        conf_byte  = 8'h00;
        sample_cnt = '0;
        id_reads   = '0;
        shift_in   = '0;
        reply      = '0;
        bit_n      = 0;
    end

    always @(negedge spi_cs_n) begin
        bit_n    = 0;
        shift_in = '0;
        spi_miso = 1'b0;
    end

    // In mode 0 the command bits are taken on the rising edge.
    always @(posedge spi_sclk) begin
        if (!spi_cs_n) begin
            shift_in = {shift_in[14:0], spi_mosi};
            bit_n    = bit_n + 1;
            if (bit_n == 8) begin
                if (shift_in[7:0] == 8'h80) begin
                    reply    = dev_id;
                    id_reads = id_reads + 1'b1;
                end else if (shift_in[7:2] == 6'd0) begin
                    // Channel read returns the running count.
                    reply      = sample_cnt[7:0];
                    sample_cnt = sample_cnt + 1'b1;
                end else begin
                    reply = 8'h00;
                end
            end
        end
    end

    // Reply byte goes out MSB first on the falling edges of bits 8 to 15.
    always @(negedge spi_sclk) begin
        if (!spi_cs_n && (bit_n >= 8) && (bit_n < 16)) begin
            spi_miso = reply[15 - bit_n];
        end
    end

    always @(posedge spi_cs_n) begin
        if ((bit_n == 16) && (shift_in[15:8] == 8'h40)) begin
            conf_byte = shift_in[7:0];
        end
    end

endmodule

/* wb_arbiter.sv */
`timescale 1ns/1ps

module wb_arbiter (
    input  logic             sys_clk,
    input  logic             rst,
    input  bus_pkg::wb_req_t m0_req,
    input  bus_pkg::wb_req_t m1_req,
    output bus_pkg::wb_rsp_t m0_rsp,
    output bus_pkg::wb_rsp_t m1_rsp,
    output bus_pkg::wb_req_t s_req,
    input  bus_pkg::wb_rsp_t s_rsp
);
    import bus_pkg::*;

    logic    gnt;
    logic    last;
    logic    active;
    wb_req_t cur;

    assign cur    = gnt ? m1_req : m0_req;
    assign s_req  = active ? cur : '0;
    assign m0_rsp = (active && !gnt) ? s_rsp : '0;
    assign m1_rsp = (active && gnt) ? s_rsp : '0;

    //////////////////////////////////////////////////////////////////////
    // Round-robin grant held for the whole cycle
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge sys_clk or posedge rst) begin
        if (rst) begin
            gnt    <= 1'b0;
            last   <= 1'b1;
            active <= 1'b0;
        end else if (!active) begin
            // m0 wins a tie when m1 had the bus last.
            if (m0_req.cyc && (!m1_req.cyc || last)) begin
                gnt    <= 1'b0;
                active <= 1'b1;
            end else if (m1_req.cyc) begin
                gnt    <= 1'b1;
                active <= 1'b1;
            end
        end else if (!cur.cyc) begin
            active <= 1'b0;
            last   <= gnt;
        end
    end

    a_ack_m0: assert property (@(posedge sys_clk) disable iff (rst)
        m0_rsp.ack |-> $past(active && !gnt && m0_req.cyc));

    a_ack_m1: assert property (@(posedge sys_clk) disable iff (rst)
        m1_rsp.ack |-> $past(active && gnt && m1_req.cyc));

endmodule
